//--- hdl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath word
`define DATA_W 32

// general register file
`define REG_ADDR_W 5
`define REG_NUM 32

// program counter
`define PC_STEP 32'd4
`define RESET_PC 32'h0000_0000

`endif

//--- hdl/mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

  //////////////////////////////
  // instruction encodings
  //////////////////////////////

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_e;

  // function field under SPECIAL
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26
  } funct_e;

  // all-zero value is the bubble
  typedef enum logic [2:0] {
    ALU_NOP,
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  //////////////////////////////
  // instruction fields
  //////////////////////////////

  // R layout; the I immediate is {rd, shamt, funct}
  typedef struct packed {
    logic [5:0]             opcode;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             shamt;
    logic [5:0]             funct;
  } inst_t;

  //////////////////////////////
  // pipeline bundles
  //////////////////////////////

  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]     data;
  } reg_wr_t;

  typedef struct packed {
    alu_op_e                alu_op;
    mem_op_e                mem_op;
    logic [`DATA_W-1:0]     op_a;
    logic [`DATA_W-1:0]     op_b;
    logic [`DATA_W-1:0]     store_data;
    logic                   we;
    logic [`REG_ADDR_W-1:0] waddr;
  } id_ex_t;

  // result doubles as the data RAM address
  typedef struct packed {
    mem_op_e                mem_op;
    logic [`DATA_W-1:0]     result;
    logic [`DATA_W-1:0]     store_data;
    logic                   we;
    logic [`REG_ADDR_W-1:0] waddr;
  } ex_mem_t;

endpackage

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module fetch_stage (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               stall_i,
  input  logic [`DATA_W-1:0] inst_i,
  output logic [`DATA_W-1:0] inst_addr_o,
  output logic               inst_ce_o,
  output logic [`DATA_W-1:0] if_pc_o,
  output logic [`DATA_W-1:0] if_inst_o
);

  logic [`DATA_W-1:0] pc_q;
  logic               ce_q;

  // fetch enable comes up one cycle after reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ce_q <= 1'b0;
    end else begin
      ce_q <= 1'b1;
    end
  end

  // pc holds while decode asks for a stall
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= `RESET_PC;
    end else if (ce_q && !stall_i) begin
      pc_q <= pc_q + `PC_STEP;
    end
  end

  //////////////////////////////
  // IF/ID register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      if_inst_o <= '0;
    end else if (!stall_i) begin
      // zero word is a no-op while fetch is off
      if_inst_o <= ce_q ? inst_i : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      if_pc_o <= pc_q;
    end
  end

  assign inst_addr_o = pc_q;
  assign inst_ce_o   = ce_q;

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic [`DATA_W-1:0]     if_inst_i,
  output logic [`REG_ADDR_W-1:0] rs_addr_o,
  output logic [`REG_ADDR_W-1:0] rt_addr_o,
  input  logic [`DATA_W-1:0]     rs_data_i,
  input  logic [`DATA_W-1:0]     rt_data_i,
  input  mips_pkg::reg_wr_t      ex_fwd_i,
  input  mips_pkg::reg_wr_t      mem_fwd_i,
  output logic                   stall_o,
  output mips_pkg::id_ex_t       id_ex_o
);

  mips_pkg::inst_t        inst;
  logic [15:0]            imm16;
  mips_pkg::alu_op_e      alu_op;
  mips_pkg::mem_op_e      mem_op;
  logic                   we;
  logic [`REG_ADDR_W-1:0] waddr;
  logic                   use_imm;
  logic                   rs_used;
  logic                   rt_used;
  logic [`DATA_W-1:0]     imm_ext;
  logic [`DATA_W-1:0]     rs_val;
  logic [`DATA_W-1:0]     rt_val;
  mips_pkg::id_ex_t       id_ex_d;

  // execute first, then memory, then the register file
  function automatic logic [`DATA_W-1:0] pick_operand(
    input logic [`REG_ADDR_W-1:0] addr,
    input logic [`DATA_W-1:0]     rf_data,
    input mips_pkg::reg_wr_t      ex_fwd,
    input mips_pkg::reg_wr_t      mem_fwd
  );
    if (addr != '0 && ex_fwd.we && ex_fwd.addr == addr) begin
      return ex_fwd.data;
    end
    if (addr != '0 && mem_fwd.we && mem_fwd.addr == addr) begin
      return mem_fwd.data;
    end
    return rf_data;
  endfunction

  assign inst      = if_inst_i;
  assign imm16     = {inst.rd, inst.shamt, inst.funct};
  assign rs_addr_o = inst.rs;
  assign rt_addr_o = inst.rt;

  //////////////////////////////
  // opcode decode
  //////////////////////////////
  always_comb begin
    alu_op  = mips_pkg::ALU_NOP;
    mem_op  = mips_pkg::MEM_NONE;
    we      = 1'b0;
    waddr   = inst.rt;
    use_imm = 1'b1;
    rs_used = 1'b1;
    rt_used = 1'b0;
    imm_ext = {16'b0, imm16};
    case (inst.opcode)
      mips_pkg::OP_SPECIAL: begin
        waddr   = inst.rd;
        use_imm = 1'b0;
        rt_used = 1'b1;
        we      = 1'b1;
        case (inst.funct)
          mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
          mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
          default: begin
            // unknown function, treated as a no-op
            we      = 1'b0;
            rs_used = 1'b0;
            rt_used = 1'b0;
          end
        endcase
      end
      mips_pkg::OP_ORI: begin
        alu_op = mips_pkg::ALU_OR;
        we     = 1'b1;
      end
      mips_pkg::OP_ANDI: begin
        alu_op = mips_pkg::ALU_AND;
        we     = 1'b1;
      end
      mips_pkg::OP_XORI: begin
        alu_op = mips_pkg::ALU_XOR;
        we     = 1'b1;
      end
      mips_pkg::OP_ADDIU: begin
        alu_op  = mips_pkg::ALU_ADD;
        we      = 1'b1;
        imm_ext = {{16{imm16[15]}}, imm16};
      end
      mips_pkg::OP_LUI: begin
        alu_op  = mips_pkg::ALU_LUI;
        we      = 1'b1;
        rs_used = 1'b0;
        imm_ext = {imm16, 16'b0};
      end
      mips_pkg::OP_LW: begin
        alu_op  = mips_pkg::ALU_ADD;
        mem_op  = mips_pkg::MEM_LOAD;
        we      = 1'b1;
        imm_ext = {{16{imm16[15]}}, imm16};
      end
      mips_pkg::OP_SW: begin
        alu_op  = mips_pkg::ALU_ADD;
        mem_op  = mips_pkg::MEM_STORE;
        rt_used = 1'b1;
        imm_ext = {{16{imm16[15]}}, imm16};
      end
      default: rs_used = 1'b0;
    endcase
  end

  assign rs_val = pick_operand(inst.rs, rs_data_i, ex_fwd_i, mem_fwd_i);
  assign rt_val = pick_operand(inst.rt, rt_data_i, ex_fwd_i, mem_fwd_i);

  // load in execute whose data is needed here
  assign stall_o = (id_ex_o.mem_op == mips_pkg::MEM_LOAD) && id_ex_o.we &&
                   (id_ex_o.waddr != '0) &&
                   ((rs_used && id_ex_o.waddr == inst.rs) ||
                    (rt_used && id_ex_o.waddr == inst.rt));

  assign id_ex_d = '{alu_op:     alu_op,
                     mem_op:     mem_op,
                     op_a:       rs_val,
                     op_b:       use_imm ? imm_ext : rt_val,
                     store_data: rt_val,
                     we:         we,
                     waddr:      waddr};

  //////////////////////////////
  // ID/EX register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_o <= '0;
    end else if (stall_o) begin
      id_ex_o <= '0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic [`REG_ADDR_W-1:0] rs_addr_i,
  input  logic [`REG_ADDR_W-1:0] rt_addr_i,
  output logic [`DATA_W-1:0]     rs_data_o,
  output logic [`DATA_W-1:0]     rt_data_o,
  input  mips_pkg::reg_wr_t      wr_i
);

  logic [`DATA_W-1:0] regs [`REG_NUM];

  // r0 is hardwired, same-cycle write passes straight through
  function automatic logic [`DATA_W-1:0] read_port(
    input logic [`REG_ADDR_W-1:0] addr,
    input logic [`DATA_W-1:0]     stored,
    input mips_pkg::reg_wr_t      wr
  );
    if (addr == '0) begin
      return '0;
    end
    if (wr.we && wr.addr == addr) begin
      return wr.data;
    end
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we && wr_i.addr != '0) begin
      regs[wr_i.addr] <= wr_i.data;
    end
  end

  assign rs_data_o = read_port(rs_addr_i, regs[rs_addr_i], wr_i);
  assign rt_data_o = read_port(rt_addr_i, regs[rt_addr_i], wr_i);

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module execute_stage (
  input  logic               clk,
  input  logic               reset_i,
  input  mips_pkg::id_ex_t   id_ex_i,
  output mips_pkg::reg_wr_t  ex_fwd_o,
  output mips_pkg::ex_mem_t  ex_mem_o
);

  logic [`DATA_W-1:0] alu_result;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (id_ex_i.alu_op)
      mips_pkg::ALU_OR:  alu_result = id_ex_i.op_a | id_ex_i.op_b;
      mips_pkg::ALU_AND: alu_result = id_ex_i.op_a & id_ex_i.op_b;
      mips_pkg::ALU_XOR: alu_result = id_ex_i.op_a ^ id_ex_i.op_b;
      mips_pkg::ALU_ADD: alu_result = id_ex_i.op_a + id_ex_i.op_b;
      mips_pkg::ALU_SUB: alu_result = id_ex_i.op_a - id_ex_i.op_b;
      // immediate already sits in the upper half
      mips_pkg::ALU_LUI: alu_result = id_ex_i.op_b;
      default:           alu_result = '0;
    endcase
  end

  // a load result only exists after the RAM read
  assign ex_fwd_o = '{we:   id_ex_i.we && (id_ex_i.mem_op != mips_pkg::MEM_LOAD),
                      addr: id_ex_i.waddr,
                      data: alu_result};

  //////////////////////////////
  // EX/MEM register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_mem_o <= '0;
    end else begin
      ex_mem_o <= '{mem_op:     id_ex_i.mem_op,
                    result:     alu_result,
                    store_data: id_ex_i.store_data,
                    we:         id_ex_i.we,
                    waddr:      id_ex_i.waddr};
    end
  end

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module memory_stage (
  input  logic               clk,
  input  logic               reset_i,
  input  mips_pkg::ex_mem_t  ex_mem_i,
  input  logic [`DATA_W-1:0] ram_data_i,
  output logic               ram_ce_o,
  output logic               ram_we_o,
  output logic [`DATA_W-1:0] ram_addr_o,
  output logic [`DATA_W-1:0] ram_data_o,
  output mips_pkg::reg_wr_t  mem_fwd_o,
  output mips_pkg::reg_wr_t  wb_o
);

  logic               is_load;
  logic [`DATA_W-1:0] stage_data;

  // data RAM request
  assign is_load    = (ex_mem_i.mem_op == mips_pkg::MEM_LOAD);
  assign ram_ce_o   = (ex_mem_i.mem_op != mips_pkg::MEM_NONE);
  assign ram_we_o   = (ex_mem_i.mem_op == mips_pkg::MEM_STORE);
  assign ram_addr_o = ex_mem_i.result;
  assign ram_data_o = ex_mem_i.store_data;

  // load word or the ALU result
  assign stage_data = is_load ? ram_data_i : ex_mem_i.result;

  assign mem_fwd_o = '{we:   ex_mem_i.we,
                       addr: ex_mem_i.waddr,
                       data: stage_data};

  //////////////////////////////
  // MEM/WB register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_o <= '0;
    end else begin
      wb_o <= mem_fwd_o;
    end
  end

endmodule

//--- hdl/mips_core.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core (
  input  logic               clk,
  input  logic               reset_i,
  input  logic [`DATA_W-1:0] inst_i,
  output logic [`DATA_W-1:0] inst_addr_o,
  output logic               inst_ce_o,
  input  logic [`DATA_W-1:0] ram_data_i,
  output logic               ram_ce_o,
  output logic               ram_we_o,
  output logic [`DATA_W-1:0] ram_addr_o,
  output logic [`DATA_W-1:0] ram_data_o
);

  //////////////////////////////
  // stage to stage
  //////////////////////////////
  logic                   stall;
  logic [`DATA_W-1:0]     if_inst;
  mips_pkg::id_ex_t       id_ex;
  mips_pkg::ex_mem_t      ex_mem;

  // register file ports
  logic [`REG_ADDR_W-1:0] rs_addr;
  logic [`REG_ADDR_W-1:0] rt_addr;
  logic [`DATA_W-1:0]     rs_data;
  logic [`DATA_W-1:0]     rt_data;
  mips_pkg::reg_wr_t      wb;

  // results fed back into decode
  mips_pkg::reg_wr_t      ex_fwd;
  mips_pkg::reg_wr_t      mem_fwd;

  fetch_stage u_fetch (
    .clk         (clk),
    .reset_i     (reset_i),
    .stall_i     (stall),
    .inst_i      (inst_i),
    .inst_addr_o (inst_addr_o),
    .inst_ce_o   (inst_ce_o),
    .if_pc_o     (),
    .if_inst_o   (if_inst)
  );

  decode_stage u_decode (
    .clk       (clk),
    .reset_i   (reset_i),
    .if_inst_i (if_inst),
    .rs_addr_o (rs_addr),
    .rt_addr_o (rt_addr),
    .rs_data_i (rs_data),
    .rt_data_i (rt_data),
    .ex_fwd_i  (ex_fwd),
    .mem_fwd_i (mem_fwd),
    .stall_o   (stall),
    .id_ex_o   (id_ex)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .reset_i   (reset_i),
    .rs_addr_i (rs_addr),
    .rt_addr_i (rt_addr),
    .rs_data_o (rs_data),
    .rt_data_o (rt_data),
    .wr_i      (wb)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset_i  (reset_i),
    .id_ex_i  (id_ex),
    .ex_fwd_o (ex_fwd),
    .ex_mem_o (ex_mem)
  );

  memory_stage u_memory (
    .clk        (clk),
    .reset_i    (reset_i),
    .ex_mem_i   (ex_mem),
    .ram_data_i (ram_data_i),
    .ram_ce_o   (ram_ce_o),
    .ram_we_o   (ram_we_o),
    .ram_addr_o (ram_addr_o),
    .ram_data_o (ram_data_o),
    .mem_fwd_o  (mem_fwd),
    .wb_o       (wb)
  );

endmodule

//--- test/mips_core_sva.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core_sva (
  input logic               clk,
  input logic               reset_i,
  input logic [`DATA_W-1:0] inst_addr_o,
  input logic               ram_ce_o,
  input logic               ram_we_o
);

  // failures seen so far, read by the testbench top
  int assert_fails = 0;

  // a RAM write always comes with chip enable
  we_needs_ce: assert property (@(posedge clk) disable iff (reset_i)
    ram_we_o |-> ram_ce_o)
    else begin
      $error("ram_we_o high while ram_ce_o is low");
      assert_fails++;
    end

  // fetch restarts at the reset vector
  pc_after_reset: assert property (@(posedge clk)
    $fell(reset_i) |-> (inst_addr_o == `RESET_PC))
    else begin
      $error("inst_addr_o not at the reset PC after reset");
      assert_fails++;
    end

  // pc either holds (stall, fetch off) or steps by one word
  pc_step: assert property (@(posedge clk) disable iff (reset_i)
    (inst_addr_o == $past(inst_addr_o)) ||
    (inst_addr_o == $past(inst_addr_o) + `PC_STEP))
    else begin
      $error("inst_addr_o changed by an illegal amount");
      assert_fails++;
    end

endmodule

bind mips_core mips_core_sva u_sva (
  .clk         (clk),
  .reset_i     (reset_i),
  .inst_addr_o (inst_addr_o),
  .ram_ce_o    (ram_ce_o),
  .ram_we_o    (ram_we_o)
);

//--- test/mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core_tb;

  localparam int NUM_TESTS     = 9;
  localparam int MAX_LEN       = 8;
  localparam int PAD_NOPS      = 4;
  localparam int IMEM_WORDS    = 1024;
  localparam int DMEM_WORDS    = 256;
  localparam int STORE_TIMEOUT = 100;

  logic               clk;
  logic               reset_i;
  logic [`DATA_W-1:0] inst_i;
  logic [`DATA_W-1:0] inst_addr_o;
  logic               inst_ce_o;
  logic [`DATA_W-1:0] ram_data_i;
  logic               ram_ce_o;
  logic               ram_we_o;
  logic [`DATA_W-1:0] ram_addr_o;
  logic [`DATA_W-1:0] ram_data_o;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] model_mem [DMEM_WORDS];
  logic [31:0] model_regs [32];
  logic [63:0] store_log [$];

  //////////////////////////////
  // stimulus table
  //////////////////////////////
  string       test_name [NUM_TESTS];
  logic [31:0] prog [NUM_TESTS][MAX_LEN];
  int          prog_len [NUM_TESTS];
  logic [31:0] exp_addr [NUM_TESTS];
  logic [31:0] exp_data [NUM_TESTS];
  int          cur_row = -1;
  int          reset_errs = 0;

  mips_core DUT (
    .clk         (clk),
    .reset_i     (reset_i),
    .inst_i      (inst_i),
    .inst_addr_o (inst_addr_o),
    .inst_ce_o   (inst_ce_o),
    .ram_data_i  (ram_data_i),
    .ram_ce_o    (ram_ce_o),
    .ram_we_o    (ram_we_o),
    .ram_addr_o  (ram_addr_o),
    .ram_data_o  (ram_data_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // combinational memories, RAM writes on the edge
  assign inst_i     = imem[inst_addr_o[11:2]];
  assign ram_data_i = dmem[ram_addr_o[9:2]];

  always @(posedge clk) begin
    if (ram_ce_o && ram_we_o) begin
      dmem[ram_addr_o[9:2]] <= ram_data_o;
      store_log.push_back({ram_addr_o, ram_data_o});
    end
  end

  function automatic logic [31:0] fill_word(input int idx);
    logic [7:0] b;
    b = idx[7:0];
    return {b, ~b, b ^ 8'h5a, b + 8'h33};
  endfunction

  function automatic logic [31:0] enc_r(input mips_pkg::funct_e fn,
                                        input logic [4:0] rd, input logic [4:0] rs,
                                        input logic [4:0] rt);
    return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(input mips_pkg::opcode_e op,
                                        input logic [4:0] rt, input logic [4:0] rs,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [15:0] rnd16();
    return 16'($urandom);
  endfunction

  task automatic start_row(input string name);
    cur_row++;
    test_name[cur_row] = name;
    prog_len[cur_row]  = 0;
  endtask

  task automatic put_inst(input logic [31:0] word);
    prog[cur_row][prog_len[cur_row]] = word;
    prog_len[cur_row]++;
  endtask

  task automatic put_nops(input int n);
    for (int i = 0; i < n; i++) begin
      put_inst(32'h0);
    end
  endtask

  // every row ends with one store to its own address
  task automatic put_store(input logic [4:0] rt);
    put_inst(enc_i(mips_pkg::OP_SW, rt, 5'd0, 16'h0200 + 16'(cur_row * 4)));
  endtask

  task automatic build_table();
    start_row("lui");
    put_inst(enc_i(mips_pkg::OP_LUI, 5'd1, 5'd0, rnd16()));
    put_nops(3);
    put_store(5'd1);
    // top bit set so zero extension shows
    start_row("ori");
    put_inst(enc_i(mips_pkg::OP_ORI, 5'd2, 5'd1, rnd16() | 16'h8000));
    put_nops(3);
    put_store(5'd2);
    start_row("andi");
    put_inst(enc_i(mips_pkg::OP_ANDI, 5'd3, 5'd2, rnd16() | 16'h8000));
    put_nops(3);
    put_store(5'd3);
    start_row("xori");
    put_inst(enc_i(mips_pkg::OP_XORI, 5'd4, 5'd2, rnd16() | 16'h8000));
    put_nops(3);
    put_store(5'd4);
    // negative offset for the sign extension
    start_row("addiu");
    put_inst(enc_i(mips_pkg::OP_ADDIU, 5'd5, 5'd2, rnd16() | 16'h8000));
    put_nops(3);
    put_store(5'd5);
    start_row("fwd_ex");
    put_inst(enc_r(mips_pkg::FN_ADDU, 5'd6, 5'd2, 5'd4));
    put_inst(enc_r(mips_pkg::FN_SUBU, 5'd7, 5'd6, 5'd5));
    put_inst(enc_r(mips_pkg::FN_XOR, 5'd8, 5'd7, 5'd2));
    put_inst(enc_r(mips_pkg::FN_AND, 5'd9, 5'd8, 5'd6));
    put_inst(enc_r(mips_pkg::FN_OR, 5'd10, 5'd9, 5'd7));
    put_store(5'd10);
    // two apart from memory, three apart through the register file
    start_row("fwd_mem");
    put_inst(enc_i(mips_pkg::OP_ADDIU, 5'd11, 5'd0, rnd16()));
    put_nops(1);
    put_inst(enc_r(mips_pkg::FN_ADDU, 5'd12, 5'd11, 5'd11));
    put_inst(enc_i(mips_pkg::OP_ADDIU, 5'd13, 5'd0, rnd16()));
    put_nops(2);
    put_inst(enc_r(mips_pkg::FN_SUBU, 5'd14, 5'd13, 5'd12));
    put_store(5'd14);
    start_row("load_use");
    put_inst(enc_i(mips_pkg::OP_LW, 5'd15, 5'd0, 16'h0040));
    put_inst(enc_r(mips_pkg::FN_ADDU, 5'd16, 5'd15, 5'd2));
    put_store(5'd16);
    start_row("reg_zero");
    put_inst(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd0, rnd16() | 16'h0001));
    put_nops(3);
    put_store(5'd0);
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  task automatic model_write(input logic [4:0] dst, input logic [31:0] val);
    if (dst != 5'd0) begin
      model_regs[dst] = val;
    end
  endtask

  task automatic model_exec(input logic [31:0] inst, input int row);
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] zext;
    logic [31:0] sext;
    rs   = inst[25:21];
    rt   = inst[20:16];
    rd   = inst[15:11];
    a    = model_regs[rs];
    b    = model_regs[rt];
    zext = {16'h0, inst[15:0]};
    sext = {{16{inst[15]}}, inst[15:0]};
    case (inst[31:26])
      mips_pkg::OP_SPECIAL: begin
        case (inst[5:0])
          mips_pkg::FN_OR:   model_write(rd, a | b);
          mips_pkg::FN_AND:  model_write(rd, a & b);
          mips_pkg::FN_XOR:  model_write(rd, a ^ b);
          mips_pkg::FN_ADDU: model_write(rd, a + b);
          mips_pkg::FN_SUBU: model_write(rd, a - b);
          default: ;
        endcase
      end
      mips_pkg::OP_ORI:   model_write(rt, a | zext);
      mips_pkg::OP_ANDI:  model_write(rt, a & zext);
      mips_pkg::OP_XORI:  model_write(rt, a ^ zext);
      mips_pkg::OP_ADDIU: model_write(rt, a + sext);
      mips_pkg::OP_LUI:   model_write(rt, {inst[15:0], 16'h0});
      mips_pkg::OP_LW:    model_write(rt, model_mem[(a + sext) >> 2]);
      mips_pkg::OP_SW: begin
        exp_addr[row] = a + sext;
        exp_data[row] = b;
        model_mem[(a + sext) >> 2] = b;
      end
      default: ;
    endcase
  endtask

  task automatic check_idle(input string phase);
    if (inst_addr_o !== `RESET_PC) begin
      $display("CHECK FAILED reset (%s) inst_addr_o expected %h actual %h",
               phase, `RESET_PC, inst_addr_o);
      reset_errs++;
    end
    if (ram_ce_o !== 1'b0 || ram_we_o !== 1'b0) begin
      $display("CHECK FAILED reset (%s) ram_ce_o/ram_we_o expected 00 actual %b%b",
               phase, ram_ce_o, ram_we_o);
      reset_errs++;
    end
  endtask

  initial begin
    int          pc;
    int          waited;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    bit          row_ok;
    logic [63:0] entry;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    reset_i      = 1'b1;
    void'($urandom(32'hf7711769));
    build_table();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]      = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = 32'h0;
    end
    // rows back to back, padded with no-ops
    pc = 0;
    for (int r = 0; r < NUM_TESTS; r++) begin
      for (int k = 0; k < prog_len[r]; k++) begin
        imem[pc] = prog[r][k];
        model_exec(prog[r][k], r);
        pc++;
      end
      pc += PAD_NOPS;
    end

    // three reset edges, outputs checked between them
    @(posedge clk);
    for (int i = 0; i < 2; i++) begin
      @(negedge clk);
      check_idle("during");
      if (inst_ce_o !== 1'b0) begin
        $display("CHECK FAILED reset (during) inst_ce_o expected 0 actual %b", inst_ce_o);
        reset_errs++;
      end
      @(posedge clk);
    end
    reset_i <= 1'b0;
    @(negedge clk);
    check_idle("first cycle after");
    // fetch enable is up from the second cycle after reset
    @(negedge clk);
    if (inst_ce_o !== 1'b1) begin
      $display("CHECK FAILED reset (after) inst_ce_o expected 1 actual %b", inst_ce_o);
      reset_errs++;
    end
    tests_run++;
    if (reset_errs != 0) begin
      tests_failed++;
    end
    $display("reset %s", (reset_errs == 0) ? "ok" : "mismatch");

    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      waited = 0;
      while (store_log.size() == 0 && waited < STORE_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      tests_run++;
      if (store_log.size() == 0) begin
        $display("timeout: test %s saw no store within %0d cycles", test_name[t],
                 STORE_TIMEOUT);
        tests_failed++;
        timed_out = 1'b1;
      end else begin
        entry  = store_log.pop_front();
        row_ok = 1'b1;
        if (entry[63:32] !== exp_addr[t]) begin
          $display("CHECK FAILED %s address expected %h actual %h", test_name[t],
                   exp_addr[t], entry[63:32]);
          row_ok = 1'b0;
        end
        if (entry[31:0] !== exp_data[t]) begin
          $display("CHECK FAILED %s data expected %h actual %h", test_name[t],
                   exp_data[t], entry[31:0]);
          row_ok = 1'b0;
        end
        if (!row_ok) begin
          tests_failed++;
        end
        $display("%s %s", test_name[t], row_ok ? "ok" : "mismatch");
      end
    end

    $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d", tests_run,
             tests_run - tests_failed, tests_failed, DUT.u_sva.assert_fails);
    if (tests_failed == 0 && DUT.u_sva.assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_core.sv
test/mips_core_sva.sv
test/mips_core_tb.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - hdl

sources:
  - hdl/mips_pkg.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/reg_file.sv
  - hdl/execute_stage.sv
  - hdl/memory_stage.sv
  - hdl/mips_core.sv
  - target: test
    files:
      - test/mips_core_sva.sv
      - test/mips_core_tb.sv
